//--- verilog/dsp_slice_cfg.svh
// DSP slice configuration.
// Operand widths, ALU segment widths and the rounding constant
// used as a W operand source.

`ifndef DSP_SLICE_CFG_SVH
`define DSP_SLICE_CFG_SVH

// ==============================
// Operand widths
// ==============================
`define DSP_A_W 30
`define DSP_B_W 18
`define DSP_P_W 48

// ==============================
// ALU segments, low to high
// ==============================
`define DSP_SEG0_W 27
`define DSP_SEG1_W 18
`define DSP_SEG2_W 3

// Half an LSB when the product is scaled down by 2^17.
`define DSP_RND 48'h0000_0001_0000

`endif

//--- verilog/dsp_slice_pkg.sv
// DSP slice shared types.
// Stage registers, ALU operand set, result word and ALU operations.

`default_nettype none

`include "dsp_slice_cfg.svh"

package dsp_slice_pkg;

	typedef struct packed {
		logic [8:0] opmode;
		logic [3:0] alumode;
		logic use_simd;
		logic cin;
	} ctrl_t;

	typedef struct packed {
		logic [`DSP_A_W-1:0] a;
		logic [`DSP_B_W-1:0] b;
		logic [`DSP_P_W-1:0] c;
		ctrl_t ctrl;
	} in_stage_t;

	typedef struct packed {
		logic [`DSP_P_W-1:0] prod;
		logic [`DSP_P_W-1:0] ab;
		logic [`DSP_P_W-1:0] c;
		ctrl_t ctrl;
	} mul_stage_t;

	typedef struct packed {
		logic [`DSP_P_W-1:0] w;
		logic [`DSP_P_W-1:0] x;
		logic [`DSP_P_W-1:0] y;
		logic [`DSP_P_W-1:0] z;
	} alu_ops_t;

	// Result seen either as one word or as its three ALU segments.
	typedef union packed {
		logic [`DSP_P_W-1:0] word;
		struct packed {
			logic [`DSP_SEG2_W-1:0] seg2;
			logic [`DSP_SEG1_W-1:0] seg1;
			logic [`DSP_SEG0_W-1:0] seg0;
		} seg;
	} p_word_u;

	typedef enum logic [1:0] {
		op_sum = 2'b00,
		op_xor = 2'b01,
		op_and = 2'b10,
		op_or  = 2'b11
	} alu_op_e;

endpackage

`default_nettype wire

//--- verilog/dsp_input_stage.sv
// DSP slice input stage.
// Registers the A, B and C operands with OPMODE, ALUMODE,
// the SIMD select and the carry in.

`timescale 1ns/1ps
`default_nettype none

`include "dsp_slice_cfg.svh"

module dsp_input_stage (
	input wire clk,
	input wire rst,
	input wire [`DSP_A_W-1:0] a,
	input wire [`DSP_B_W-1:0] b,
	input wire [`DSP_P_W-1:0] c,
	input wire [8:0] opmode,
	input wire [3:0] alumode,
	input wire use_simd,
	input wire cin,
	output dsp_slice_pkg::in_stage_t q
);

	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
		end else begin
			q.a <= a;
			q.b <= b;
			q.c <= c;
			q.ctrl.opmode <= opmode;
			q.ctrl.alumode <= alumode;
			q.ctrl.use_simd <= use_simd;
			q.ctrl.cin <= cin;
		end
	end

	// Only sum, subtract, XOR and AND/OR are modelled.
	assert property (@(posedge clk) disable iff (rst)
		alumode inside {4'b0000, 4'b0011, 4'b0100, 4'b1100})
		else $error("unsupported ALUMODE %b", alumode);

endmodule

`default_nettype wire

//--- verilog/dsp_multiply_stage.sv
// DSP slice multiply stage.
// Forms the signed 27x18 product of A and B, sign-extended to
// the P width, and registers it with A:B, C and the controls.

`timescale 1ns/1ps
`default_nettype none

`include "dsp_slice_cfg.svh"

module dsp_multiply_stage (
	input wire clk,
	input wire rst,
	input wire dsp_slice_pkg::in_stage_t d,
	output dsp_slice_pkg::mul_stage_t q
);

	// The multiplier A port is as wide as the low ALU segment.
	localparam int unsigned prod_w = `DSP_SEG0_W + `DSP_B_W;

	logic signed [prod_w-1:0] prod;

	assign prod = prod_w'($signed(d.a[`DSP_SEG0_W-1:0])) * prod_w'($signed(d.b));

	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
		end else begin
			q.prod <= {{(`DSP_P_W - prod_w){prod[prod_w-1]}}, prod};
			q.ab <= {d.a, d.b};
			q.c <= d.c;
			q.ctrl <= d.ctrl;
		end
	end

endmodule

`default_nettype wire

//--- verilog/dsp_operand_mux.sv
// DSP slice operand mux.
// Picks the W, X, Y and Z ALU operands from the OPMODE fields,
// with P fed back for accumulation.

`timescale 1ns/1ps
`default_nettype none

`include "dsp_slice_cfg.svh"

module dsp_operand_mux (
	input wire dsp_slice_pkg::mul_stage_t d,
	input wire [`DSP_P_W-1:0] p,
	output dsp_slice_pkg::alu_ops_t ops
);

	logic reserved_sel;

	always_comb begin
		case (d.ctrl.opmode[1:0])
			2'd1: ops.x = d.prod;
			2'd3: ops.x = d.ab;
			default: ops.x = '0;
		endcase

		case (d.ctrl.opmode[3:2])
			2'd2: ops.y = '1;
			2'd3: ops.y = d.c;
			default: ops.y = '0;
		endcase

		case (d.ctrl.opmode[6:4])
			3'd1: ops.z = p;
			3'd3: ops.z = d.c;
			default: ops.z = '0;
		endcase

		case (d.ctrl.opmode[8:7])
			2'd1: ops.w = p;
			2'd2: ops.w = `DSP_RND;
			2'd3: ops.w = d.c;
			default: ops.w = '0;
		endcase
	end

	// Reserved codes fall through to zero above.
	assign reserved_sel = (d.ctrl.opmode[1:0] == 2'd2) || (d.ctrl.opmode[3:2] == 2'd1) ||
		!(d.ctrl.opmode[6:4] inside {3'd0, 3'd1, 3'd3});

	always_comb begin
		assert (reserved_sel !== 1'b1)
			else $error("reserved OPMODE select %b", d.ctrl.opmode);
	end

endmodule

`default_nettype wire

//--- verilog/dsp_alu_segment.sv
// DSP slice ALU segment.
// Three-operand add of W, X and Y plus a carry in, then added to
// an optionally inverted Z; the sum may be inverted for subtraction.
// Logic ops return the bitwise result of X and Z.

`timescale 1ns/1ps
`default_nettype none

module dsp_alu_segment #(
	parameter int unsigned width = 27
) (
	input wire [width-1:0] w,
	input wire [width-1:0] x,
	input wire [width-1:0] y,
	input wire [width-1:0] z,
	input wire dsp_slice_pkg::alu_op_e op,
	input wire z_neg,
	input wire s_neg,
	input wire [1:0] cin,
	output logic [width-1:0] s,
	output logic [1:0] cout
);

	import dsp_slice_pkg::*;

	logic [width-1:0] z_in;
	logic [width+1:0] wxy;
	logic [width+1:0] total;

	// Two guard bits hold the worst case of four operands plus carry.
	assign z_in = z_neg ? ~z : z;
	assign wxy = (width + 2)'(w) + (width + 2)'(x) + (width + 2)'(y) + (width + 2)'(cin);
	assign total = wxy + (width + 2)'(z_in);

	always_comb begin
		case (op)
			op_xor: begin
				s = x ^ z;
				cout = 2'b00;
			end
			op_and: begin
				s = x & z;
				cout = 2'b00;
			end
			op_or: begin
				s = x | z;
				cout = 2'b00;
			end
			default: begin
				// ~(~Z + V) equals Z - V.
				s = s_neg ? ~total[width-1:0] : total[width-1:0];
				cout = total[width+1:width];
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/dsp_segmented_alu.sv
// DSP slice segmented ALU.
// Decodes ALUMODE, chains the 27, 18 and 3 bit segments, breaks
// the chain in SIMD mode and registers P and the carry flags.

`timescale 1ns/1ps
`default_nettype none

`include "dsp_slice_cfg.svh"

module dsp_segmented_alu (
	input wire clk,
	input wire rst,
	input wire dsp_slice_pkg::mul_stage_t d,
	input wire dsp_slice_pkg::alu_ops_t ops,
	output logic [`DSP_P_W-1:0] p,
	output logic carry_out,
	output logic [1:0] simd_carry
);

	import dsp_slice_pkg::*;

	localparam int unsigned s1_lo = `DSP_SEG0_W;
	localparam int unsigned s2_lo = `DSP_SEG0_W + `DSP_SEG1_W;

	alu_op_e op;
	logic sub;
	logic [1:0] cin0, cin1;
	logic [1:0] cout0, cout1, cout2;
	logic [`DSP_SEG0_W-1:0] s0;
	logic [`DSP_SEG1_W-1:0] s1;
	logic [`DSP_SEG2_W-1:0] s2;
	p_word_u s_u;

	// ==============================
	// ALUMODE decode
	// ==============================
	always_comb begin
		case (d.ctrl.alumode[3:2])
			2'b01: op = op_xor;
			2'b11: op = d.ctrl.opmode[3] ? op_or : op_and;
			default: op = op_sum;
		endcase
	end

	assign sub = (d.ctrl.alumode == 4'b0011);

	// SIMD keeps the two low segments apart, segment 2 still chains.
	assign cin0 = d.ctrl.use_simd ? 2'b00 : {1'b0, d.ctrl.cin};
	assign cin1 = d.ctrl.use_simd ? 2'b00 : cout0;

	// ==============================
	// Segments
	// ==============================
	dsp_alu_segment #(.width(`DSP_SEG0_W)) u_seg0 (
		.w(ops.w[s1_lo-1:0]), .x(ops.x[s1_lo-1:0]),
		.y(ops.y[s1_lo-1:0]), .z(ops.z[s1_lo-1:0]),
		.op(op), .z_neg(sub), .s_neg(sub), .cin(cin0), .s(s0), .cout(cout0)
	);

	dsp_alu_segment #(.width(`DSP_SEG1_W)) u_seg1 (
		.w(ops.w[s2_lo-1:s1_lo]), .x(ops.x[s2_lo-1:s1_lo]),
		.y(ops.y[s2_lo-1:s1_lo]), .z(ops.z[s2_lo-1:s1_lo]),
		.op(op), .z_neg(sub), .s_neg(sub), .cin(cin1), .s(s1), .cout(cout1)
	);

	dsp_alu_segment #(.width(`DSP_SEG2_W)) u_seg2 (
		.w(ops.w[`DSP_P_W-1:s2_lo]), .x(ops.x[`DSP_P_W-1:s2_lo]),
		.y(ops.y[`DSP_P_W-1:s2_lo]), .z(ops.z[`DSP_P_W-1:s2_lo]),
		.op(op), .z_neg(sub), .s_neg(sub), .cin(cout1), .s(s2), .cout(cout2)
	);

	always_comb begin
		s_u.seg.seg0 = s0;
		s_u.seg.seg1 = s1;
		s_u.seg.seg2 = s2;
	end

	// Carry flags come from the internal adder, so subtract reports ~Z + V.
	always_ff @(posedge clk) begin
		if (rst) begin
			p <= '0;
			carry_out <= 1'b0;
			simd_carry <= 2'b00;
		end else begin
			p <= s_u.word;
			carry_out <= |cout2;
			simd_carry <= {|cout1, |cout0};
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(op != op_sum) |=> (carry_out == 1'b0 && simd_carry == 2'b00))
		else $error("carry flags set after a logic op");

endmodule

`default_nettype wire

//--- verilog/dsp_slice_top.sv
// DSP slice top level.
// Input, multiply and ALU stages, three cycles from operands to P,
// with P fed back into the operand mux.

`timescale 1ns/1ps
`default_nettype none

`include "dsp_slice_cfg.svh"

module dsp_slice_top (
	input wire clk,
	input wire rst,
	input wire [`DSP_A_W-1:0] a,
	input wire [`DSP_B_W-1:0] b,
	input wire [`DSP_P_W-1:0] c,
	input wire [8:0] opmode,
	input wire [3:0] alumode,
	input wire use_simd,
	input wire cin,
	output logic [`DSP_P_W-1:0] p,
	output logic carry_out,
	output logic [1:0] simd_carry
);

	import dsp_slice_pkg::*;

	in_stage_t in_q;
	mul_stage_t mul_q;
	alu_ops_t ops;

	dsp_input_stage u_input (
		.clk(clk),
		.rst(rst),
		.a(a),
		.b(b),
		.c(c),
		.opmode(opmode),
		.alumode(alumode),
		.use_simd(use_simd),
		.cin(cin),
		.q(in_q)
	);

	dsp_multiply_stage u_multiply (
		.clk(clk),
		.rst(rst),
		.d(in_q),
		.q(mul_q)
	);

	dsp_operand_mux u_mux (
		.d(mul_q),
		.p(p),
		.ops(ops)
	);

	dsp_segmented_alu u_alu (
		.clk(clk),
		.rst(rst),
		.d(mul_q),
		.ops(ops),
		.p(p),
		.carry_out(carry_out),
		.simd_carry(simd_carry)
	);

endmodule

`default_nettype wire

//--- sim/dsp_slice_tb.sv
// DSP slice testbench.
// Applies a table of OPMODE/ALUMODE settings with fixed or LFSR
// operands, and checks P and the carry flags against a reference model.

`timescale 1ns/1ps
`default_nettype none

`include "dsp_slice_cfg.svh"

module dsp_slice_tb;

	import dsp_slice_pkg::*;

	typedef struct packed {
		logic rnd;
		logic [8:0] opmode;
		logic [3:0] alumode;
		logic use_simd;
		logic cin;
		logic [`DSP_A_W-1:0] a;
		logic [`DSP_B_W-1:0] b;
		logic [`DSP_P_W-1:0] c;
	} entry_t;

	typedef struct packed {
		logic [`DSP_P_W-1:0] p;
		logic carry_out;
		logic [1:0] simd_carry;
	} result_t;

	localparam int clk_period = 100;
	localparam int latency = 3;
	localparam int p_w = `DSP_P_W;
	localparam int mul_a_w = `DSP_SEG0_W;
	localparam int seg_w [3] = '{`DSP_SEG0_W, `DSP_SEG1_W, `DSP_SEG2_W};

	logic clk;
	logic rst;
	logic [`DSP_A_W-1:0] a;
	logic [`DSP_B_W-1:0] b;
	logic [`DSP_P_W-1:0] c;
	logic [8:0] opmode;
	logic [3:0] alumode;
	logic use_simd;
	logic cin;
	logic [`DSP_P_W-1:0] p;
	logic carry_out;
	logic [1:0] simd_carry;

	entry_t stim [$];
	result_t exp_q [$];
	logic [`DSP_P_W-1:0] model_p;
	logic [15:0] lfsr_state;
	logic table_ready = 1'b0;
	int errors;
	int checks;

	dsp_slice_top DUT (
		.clk(clk),
		.rst(rst),
		.a(a),
		.b(b),
		.c(c),
		.opmode(opmode),
		.alumode(alumode),
		.use_simd(use_simd),
		.cin(cin),
		.p(p),
		.carry_out(carry_out),
		.simd_carry(simd_carry)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Galois form, x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [`DSP_P_W-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
	endtask

	// ==============================
	// Reference model
	// ==============================
	function automatic result_t compute_expected(input entry_t e,
		input logic [`DSP_P_W-1:0] prev);
		logic [`DSP_P_W-1:0] a_ext, b_ext, prod, ab, w, x, y, z, zi;
		logic [63:0] opnd [4];
		logic [63:0] seg_s [3];
		logic [63:0] cy [3];
		logic [63:0] mask, t, cin_seg;
		logic sub;
		int lo;
		p_word_u pw;
		result_t r;

		a_ext = {{(p_w - mul_a_w){e.a[mul_a_w-1]}}, e.a[mul_a_w-1:0]};
		b_ext = {{(p_w - `DSP_B_W){e.b[`DSP_B_W-1]}}, e.b};
		prod = a_ext * b_ext;
		ab = {e.a, e.b};
		case (e.opmode[1:0])
			2'd1: x = prod;
			2'd3: x = ab;
			default: x = '0;
		endcase
		case (e.opmode[3:2])
			2'd2: y = '1;
			2'd3: y = e.c;
			default: y = '0;
		endcase
		case (e.opmode[6:4])
			3'd1: z = prev;
			3'd3: z = e.c;
			default: z = '0;
		endcase
		case (e.opmode[8:7])
			2'd1: w = prev;
			2'd2: w = `DSP_RND;
			2'd3: w = e.c;
			default: w = '0;
		endcase

		r = '0;
		if (e.alumode == 4'b0100) begin
			r.p = x ^ z;
		end else if (e.alumode == 4'b1100) begin
			r.p = e.opmode[3] ? (x | z) : (x & z);
		end else begin
			// Subtract is ~(~Z + W + X + Y + CIN) per segment.
			sub = (e.alumode == 4'b0011);
			zi = sub ? ~z : z;
			opnd[0] = {16'h0, w};
			opnd[1] = {16'h0, x};
			opnd[2] = {16'h0, y};
			opnd[3] = {16'h0, zi};
			cin_seg = e.use_simd ? 64'd0 : {63'd0, e.cin};
			lo = 0;
			for (int i = 0; i < 3; i++) begin
				mask = (64'd1 << seg_w[i]) - 64'd1;
				t = cin_seg;
				for (int k = 0; k < 4; k++) begin
					t = t + ((opnd[k] >> lo) & mask);
				end
				cy[i] = t >> seg_w[i];
				seg_s[i] = sub ? (~t & mask) : (t & mask);
				// SIMD cuts only the chain from segment 0 to segment 1.
				cin_seg = (e.use_simd && i == 0) ? 64'd0 : cy[i];
				lo = lo + seg_w[i];
			end
			pw.seg.seg0 = seg_s[0][`DSP_SEG0_W-1:0];
			pw.seg.seg1 = seg_s[1][`DSP_SEG1_W-1:0];
			pw.seg.seg2 = seg_s[2][`DSP_SEG2_W-1:0];
			r.p = pw.word;
			r.carry_out = (cy[2] != 64'd0);
			r.simd_carry = {cy[1] != 64'd0, cy[0] != 64'd0};
		end
		return r;
	endfunction

	task automatic check_outputs(input result_t exp_r, input string what);
		checks++;
		assert (p === exp_r.p)
			else begin
				errors++;
				$display("Error: p expected %h, got %h (%s)", exp_r.p, p, what);
			end
		assert (carry_out === exp_r.carry_out)
			else begin
				errors++;
				$display("Error: carry_out expected %h, got %h (%s)",
					exp_r.carry_out, carry_out, what);
			end
		assert (simd_carry === exp_r.simd_carry)
			else begin
				errors++;
				$display("Error: simd_carry expected %h, got %h (%s)",
					exp_r.simd_carry, simd_carry, what);
			end
	endtask

	task automatic apply_inputs(input entry_t e);
		a = e.a;
		b = e.b;
		c = e.c;
		opmode = e.opmode;
		alumode = e.alumode;
		use_simd = e.use_simd;
		cin = e.cin;
	endtask

	task automatic add_entry(input logic rnd, input logic [8:0] opmode_v,
		input logic [3:0] alumode_v, input logic simd_v, input logic cin_v,
		input logic [`DSP_A_W-1:0] a_v, input logic [`DSP_B_W-1:0] b_v,
		input logic [`DSP_P_W-1:0] c_v);
		entry_t e;

		e.rnd = rnd;
		e.opmode = opmode_v;
		e.alumode = alumode_v;
		e.use_simd = simd_v;
		e.cin = cin_v;
		e.a = a_v;
		e.b = b_v;
		e.c = c_v;
		stim.push_back(e);
	endtask

	// ==============================
	// Stimulus table
	// ==============================
	// OPMODE literals are grouped as W_Z_Y_X.
	task automatic load_table();
		// Signed multiply-add, X = product and Z = C.
		add_entry(1'b0, 9'b00_011_00_01, 4'b0000, 1'b0, 1'b0, 30'h1234, 18'h3fffd, 48'h1_0000);
		add_entry(1'b0, 9'b00_011_00_01, 4'b0000, 1'b0, 1'b0, 30'h07ff_ff00, 18'h00123,
			48'h100);
		add_entry(1'b0, 9'b00_011_00_01, 4'b0000, 1'b0, 1'b1, 30'h3fff_fff0, 18'h20000,
			48'hffff_ffff_ffff);
		add_entry(1'b0, 9'b00_011_00_01, 4'b0000, 1'b0, 1'b0, 30'h2000_0005, 18'h3ffff, '0);
		add_entry(1'b1, 9'b00_011_00_01, 4'b0000, 1'b0, 1'b1, '0, '0, '0);
		add_entry(1'b1, 9'b00_011_00_01, 4'b0000, 1'b0, 1'b0, '0, '0, '0);
		// Subtraction, Z = C and X = A:B.
		add_entry(1'b0, 9'b00_011_00_11, 4'b0011, 1'b0, 1'b1, 30'h1, 18'h2, 48'h1000_0000);
		add_entry(1'b0, 9'b00_011_00_11, 4'b0011, 1'b0, 1'b0, 30'h3fff_ffff, 18'h3ffff, 48'h5);
		add_entry(1'b1, 9'b00_011_00_11, 4'b0011, 1'b0, 1'b1, '0, '0, '0);
		// Rounding constant on W, and Y as all ones.
		add_entry(1'b0, 9'b10_011_00_01, 4'b0000, 1'b0, 1'b0, 30'h4000, 18'h100, '0);
		add_entry(1'b0, 9'b10_011_00_11, 4'b0011, 1'b0, 1'b0, 30'h0, 18'h1, 48'h2_0000);
		add_entry(1'b1, 9'b10_000_00_01, 4'b0000, 1'b0, 1'b0, '0, '0, '0);
		add_entry(1'b1, 9'b00_011_10_01, 4'b0000, 1'b0, 1'b1, '0, '0, '0);
		// Logic ops, OPMODE[3] picks OR over AND.
		add_entry(1'b1, 9'b00_011_00_11, 4'b0100, 1'b0, 1'b0, '0, '0, '0);
		add_entry(1'b1, 9'b00_011_00_11, 4'b1100, 1'b0, 1'b1, '0, '0, '0);
		add_entry(1'b1, 9'b00_011_10_11, 4'b1100, 1'b0, 1'b0, '0, '0, '0);
		add_entry(1'b0, 9'b00_011_11_11, 4'b1100, 1'b0, 1'b0, 30'h2aaa_aaaa, 18'h15555,
			48'h0f0f_0f0f_0f0f);
		add_entry(1'b1, 9'b00_011_00_01, 4'b0100, 1'b0, 1'b0, '0, '0, '0);
		// Same overflowing operands with and without SIMD.
		add_entry(1'b0, 9'b00_011_00_11, 4'b0000, 1'b1, 1'b1, 30'h3fff_ffff, 18'h3ffff,
			48'h0800_0001);
		add_entry(1'b0, 9'b00_011_00_11, 4'b0000, 1'b0, 1'b0, 30'h3fff_ffff, 18'h3ffff,
			48'h0800_0001);
		add_entry(1'b0, 9'b00_011_00_11, 4'b0000, 1'b1, 1'b0, 30'h1, 18'h1, 48'h0800_0002);
		add_entry(1'b1, 9'b00_011_00_11, 4'b0000, 1'b1, 1'b0, '0, '0, '0);
		add_entry(1'b1, 9'b00_011_00_11, 4'b0011, 1'b1, 1'b0, '0, '0, '0);
		// Accumulation through P feedback.
		repeat (6) begin
			add_entry(1'b1, 9'b00_001_00_01, 4'b0000, 1'b0, 1'b0, '0, '0, '0);
		end
		add_entry(1'b1, 9'b01_011_00_01, 4'b0000, 1'b0, 1'b0, '0, '0, '0);
		add_entry(1'b1, 9'b00_001_00_01, 4'b0011, 1'b0, 1'b1, '0, '0, '0);
		add_entry(1'b1, 9'b01_001_00_00, 4'b0000, 1'b0, 1'b0, '0, '0, '0);
		add_entry(1'b1, 9'b00_001_00_11, 4'b0000, 1'b1, 1'b0, '0, '0, '0);
	endtask

	initial begin
		wait (table_ready);
		#((stim.size() + 10) * clk_period);
		$display("Timeout: the run did not end within %0d clock cycles", stim.size() + 10);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		entry_t e;
		result_t r;
		logic [`DSP_P_W-1:0] rv;
		int total;

		rst = 1'b1;
		apply_inputs('0);
		lfsr_state = 16'd53;
		model_p = '0;
		errors = 0;
		checks = 0;
		load_table();
		table_ready = 1'b1;

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Each falling edge checks the item issued three edges earlier.
		total = stim.size() + latency;
		for (int i = 0; i < total; i++) begin
			if (i >= latency) begin
				r = exp_q.pop_front();
				check_outputs(r, $sformatf("item %0d", i - latency));
			end else begin
				check_outputs('0, "before first result");
			end
			if (i < stim.size()) begin
				e = stim[i];
				if (e.rnd) begin
					random_bits(`DSP_A_W, rv);
					e.a = rv[`DSP_A_W-1:0];
					random_bits(`DSP_B_W, rv);
					e.b = rv[`DSP_B_W-1:0];
					random_bits(`DSP_P_W, rv);
					e.c = rv;
				end
				r = compute_expected(e, model_p);
				model_p = r.p;
				exp_q.push_back(r);
				apply_inputs(e);
			end else begin
				apply_inputs('0);
			end
			@(negedge clk);
		end

		$display("Checks: %0d run, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verilog
verilog/dsp_slice_pkg.sv
verilog/dsp_input_stage.sv
verilog/dsp_multiply_stage.sv
verilog/dsp_operand_mux.sv
verilog/dsp_alu_segment.sv
verilog/dsp_segmented_alu.sv
verilog/dsp_slice_top.sv
sim/dsp_slice_tb.sv

//--- Makefile
# Verilator build and run for the DSP slice testbench.

VERILATOR ?= verilator
TOP ?= dsp_slice_tb
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_MSG ?= Done: errors found
PASS_MSG ?= Done: no errors

SRCS := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
